// ==== cordic_if.sv ====
// ############################
// cordic_if
// row pair into a CORDIC unit, result back
// ############################
interface cordic_if
   import qr_cordic_pkg::*;
();

   // x from the upper row, y from the lower row
   elem_t x_in;
   elem_t y_in;
   elem_t x_out;
   elem_t y_out;

   modport store (
      output x_in,
      output y_in,
      input  x_out,
      input  y_out
   );

   modport unit (
      input  x_in,
      input  y_in,
      output x_out,
      output y_out
   );

endinterface

// ==== cordic_rotate.sv ====
// ############################
// cordic_rotate
// rotation CORDIC steered by a recorded code
// ############################
module cordic_rotate
   import qr_cordic_pkg::*;
(
   input  step_t     step,
   input  rot_code_t rot_code,
   cordic_if.unit    bus
);

   logic                        flip;
   logic [$clog2(NUM_ITER)-1:0] sh0;
   logic [$clog2(NUM_ITER)-1:0] sh1;
   elem_t                       x0;
   elem_t                       y0;
   elem_t                       x1;
   elem_t                       y1;
   elem_t                       x2;
   elem_t                       y2;

   assign sh0 = {step, 1'b0};
   assign sh1 = {step, 1'b1};

   // same fold the vectoring pass applied
   assign flip = (step == 2'd0) && rot_code[NUM_ITER];
   assign x0   = flip ? -bus.x_in : bus.x_in;
   assign y0   = flip ? -bus.y_in : bus.y_in;

   always_comb begin
      micro_rot(x0, y0, rot_code[sh0], sh0, x1, y1);
      micro_rot(x1, y1, rot_code[sh1], sh1, x2, y2);
   end

   assign bus.x_out = x2;
   assign bus.y_out = y2;

endmodule

// ==== cordic_vector.sv ====
// ############################
// cordic_vector
// vectoring CORDIC, two iterations per clock
// ############################
module cordic_vector
   import qr_cordic_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  step_t     step,
   input  store_op_t op,
   cordic_if.unit    bus,
   output rot_code_t rot_code
);

   logic                        flip;
   logic                        dir0;
   logic                        dir1;
   logic [$clog2(NUM_ITER)-1:0] sh0;
   logic [$clog2(NUM_ITER)-1:0] sh1;
   elem_t                       x0;
   elem_t                       y0;
   elem_t                       x1;
   elem_t                       y1;
   elem_t                       x2;
   elem_t                       y2;

   // iterations 2*step and 2*step+1
   assign sh0 = {step, 1'b0};
   assign sh1 = {step, 1'b1};

   // half-plane fold so the final x ends up non-negative
   assign flip = (step == 2'd0) && bus.x_in[$bits(elem_t)-1];
   assign x0   = flip ? -bus.x_in : bus.x_in;
   assign y0   = flip ? -bus.y_in : bus.y_in;

   // drive y toward zero, direction from its sign
   assign dir0 = y0[$bits(elem_t)-1];
   assign dir1 = y1[$bits(elem_t)-1];

   always_comb begin
      micro_rot(x0, y0, dir0, sh0, x1, y1);
      micro_rot(x1, y1, dir1, sh1, x2, y2);
   end

   assign bus.x_out = x2;
   assign bus.y_out = y2;

   // code is replayed by the rotation unit on the other columns
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rot_code <= '0;
      end else if (op == op_vector) begin
         if (step == 2'd0) begin
            rot_code[NUM_ITER] <= flip;
         end
         rot_code[sh0] <= dir0;
         rot_code[sh1] <= dir1;
      end
   end

endmodule

// ==== givens_sequencer.sv ====
// ############################
// givens_sequencer
// schedules load, every Givens rotation and the output beats
// ############################
module givens_sequencer
   import qr_cordic_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      valid,
   output logic      in_ready,
   output logic      out_valid,
   output store_op_t op,
   output row_idx_t  row,
   output col_idx_t  col,
   output step_t     step
);

   localparam row_idx_t LAST_ROW  = row_idx_t'(NUM_ROWS - 1);
   localparam col_idx_t LAST_COL  = col_idx_t'(NUM_COLS - 1);
   localparam step_t    LAST_STEP = step_t'(NUM_ITER / ITER_PER_CYC - 1);
   // 60 passes of four CORDIC steps plus one gain cycle
   localparam int       COMPUTE_CYC = 300;

   seq_state_t state;
   row_idx_t   row_cnt;
   // column being cleared and column being rotated
   col_idx_t   elim_col;
   col_idx_t   work_col;
   step_t      step_cnt;
   logic       pair_done;
   logic       col_done;

   assign in_ready  = (state == st_idle) || (state == st_load);
   assign out_valid = (state == st_output);
   assign row       = row_cnt;
   assign col       = work_col;
   assign step      = step_cnt;

   // last column of this pair
   assign pair_done = (work_col == LAST_COL);
   // pair sitting just below the diagonal
   assign col_done  = (row_cnt == row_idx_t'({1'b0, elim_col}) + 3'd1);

   always_comb begin
      case (state)
         st_idle, st_load: op = valid ? op_load : op_none;
         st_vector:        op = op_vector;
         st_rotate:        op = op_rotate;
         st_scale:         op = op_scale;
         default:          op = op_none;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         row_cnt  <= '0;
         elim_col <= '0;
         work_col <= '0;
         step_cnt <= '0;
      end else begin
         case (state)
            st_idle, st_load: begin
               if (valid) begin
                  if (row_cnt == LAST_ROW) begin
                     // start at the bottom pair of column 0
                     state    <= st_vector;
                     elim_col <= '0;
                     work_col <= '0;
                     step_cnt <= '0;
                  end else begin
                     row_cnt <= row_cnt + 3'd1;
                     state   <= st_load;
                  end
               end
            end
            st_vector, st_rotate: begin
               if (step_cnt == LAST_STEP) begin
                  step_cnt <= '0;
                  state    <= st_scale;
               end else begin
                  step_cnt <= step_cnt + 2'd1;
               end
            end
            st_scale: begin
               if (!pair_done) begin
                  work_col <= work_col + 2'd1;
                  state    <= st_rotate;
               end else if (!col_done) begin
                  // next pair up in the same column
                  row_cnt  <= row_cnt - 3'd1;
                  work_col <= elim_col;
                  state    <= st_vector;
               end else if (elim_col != LAST_COL) begin
                  elim_col <= elim_col + 2'd1;
                  work_col <= elim_col + 2'd1;
                  row_cnt  <= LAST_ROW;
                  state    <= st_vector;
               end else begin
                  row_cnt <= '0;
                  state   <= st_output;
               end
            end
            st_output: begin
               // wraps back to row 0 for the next load
               row_cnt <= row_cnt + 3'd1;
               if (row_cnt == LAST_ROW) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // lower row of a pair is always below the column being cleared
   a_row_below: assert property (@(posedge clk) disable iff (!rst_n)
      (state inside {st_vector, st_rotate, st_scale}) |->
      (row_cnt > row_idx_t'({1'b0, elim_col})))
      else $error("ERR %0t: row %0d not below column %0d", $time, row_cnt, elim_col);

   // output starts one full elimination schedule after input closes
   a_out_start: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(out_valid) |->
      ($past(in_ready, COMPUTE_CYC + 1) && !$past(in_ready, COMPUTE_CYC)))
      else $error("ERR %0t: output did not start %0d cycles after the last row",
         $time, COMPUTE_CYC);

endmodule

// ==== matrix_store.sv ====
// ############################
// matrix_store
// 8x4 element array with load, CORDIC write-back and gain pass
// ############################
module matrix_store
   import qr_cordic_pkg::*;
#(
   parameter int DATA_W = qr_cordic_pkg::DATA_W
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  store_op_t                  op,
   input  row_idx_t                   row,
   input  col_idx_t                   col,
   input  logic [NUM_COLS*DATA_W-1:0] in_data,
   output logic [NUM_COLS*DATA_W-1:0] out_data,
   cordic_if.store                    vec_bus,
   cordic_if.store                    rot_bus
);

   elem_t                        mem [NUM_ROWS][NUM_COLS];
   row_idx_t                     row_x;
   elem_t                        x_sel;
   elem_t                        y_sel;
   logic signed [DATA_W+K_W-1:0] prod_x;
   logic signed [DATA_W+K_W-1:0] prod_y;
   elem_t                        x_scaled;
   elem_t                        y_scaled;

   // pair is (row-1, row) at the addressed column
   assign row_x = row - 3'd1;
   assign x_sel = mem[row_x][col];
   assign y_sel = mem[row][col];

   // both units see the same pair, the op picks whose result lands
   assign vec_bus.x_in = x_sel;
   assign vec_bus.y_in = y_sel;
   assign rot_bus.x_in = x_sel;
   assign rot_bus.y_in = y_sel;

   // gain compensation, Q2.10 x Q1.10 back to Q2.10
   assign prod_x   = x_sel * CORDIC_GAIN;
   assign prod_y   = y_sel * CORDIC_GAIN;
   assign x_scaled = {prod_x[DATA_W+K_W-1], prod_x[FRAC_W+DATA_W-2:FRAC_W]};
   assign y_scaled = {prod_y[DATA_W+K_W-1], prod_y[FRAC_W+DATA_W-2:FRAC_W]};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
               mem[r][c] <= '0;
            end
         end
      end else begin
         case (op)
            op_load: begin
               // column 0 sits in the low bits
               for (int c = 0; c < NUM_COLS; c++) begin
                  mem[row][c] <= in_data[c*DATA_W +: DATA_W];
               end
            end
            op_vector: begin
               mem[row_x][col] <= vec_bus.x_out;
               mem[row][col]   <= vec_bus.y_out;
            end
            op_rotate: begin
               mem[row_x][col] <= rot_bus.x_out;
               mem[row][col]   <= rot_bus.y_out;
            end
            op_scale: begin
               mem[row_x][col] <= x_scaled;
               mem[row][col]   <= y_scaled;
            end
            default: begin
            end
         endcase
      end
   end

   // read port for the output phase
   always_comb begin
      out_data = '0;
      if (op == op_none) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            out_data[c*DATA_W +: DATA_W] = mem[row][c];
         end
      end
   end

endmodule

// ==== qr_cordic.f ====
qr_cordic_pkg.sv
cordic_if.sv
cordic_vector.sv
cordic_rotate.sv
matrix_store.sv
givens_sequencer.sv
qr_cordic_top.sv
tb_qr_cordic.sv

// ==== qr_cordic_pkg.sv ====
// ############################
// qr_cordic_pkg
// widths, CORDIC constants, store ops and sequencer states
// ############################
package qr_cordic_pkg;

   // element format is Q2.10
   parameter int DATA_W       = 13;
   parameter int FRAC_W       = 10;
   parameter int NUM_ROWS     = 8;
   parameter int NUM_COLS     = 4;
   parameter int NUM_ITER     = 8;
   parameter int ITER_PER_CYC = 2;
   parameter int K_W          = 11;

   // 1 / 1.6468 for 8 iterations, Q1.10
   parameter logic signed [K_W-1:0] CORDIC_GAIN = 11'sd622;

   typedef logic signed [DATA_W-1:0] elem_t;
   typedef logic [2:0]               row_idx_t;
   typedef logic [1:0]               col_idx_t;
   typedef logic [1:0]               step_t;
   // msb is the 180 degree flip, then one direction bit per iteration
   typedef logic [NUM_ITER:0]        rot_code_t;

   typedef enum logic [2:0] {
      op_none,
      op_load,
      op_vector,
      op_rotate,
      op_scale
   } store_op_t;

   typedef enum logic [2:0] {
      st_idle,
      st_load,
      st_vector,
      st_rotate,
      st_scale,
      st_output
   } seq_state_t;

   // one micro-rotation by atan(2^-sh), dir set turns counter-clockwise
   function automatic void micro_rot(
      input  elem_t                       x,
      input  elem_t                       y,
      input  logic                        dir,
      input  logic [$clog2(NUM_ITER)-1:0] sh,
      output elem_t                       x_o,
      output elem_t                       y_o
   );
      if (dir) begin
         x_o = x - (y >>> sh);
         y_o = y + (x >>> sh);
      end else begin
         x_o = x + (y >>> sh);
         y_o = y - (x >>> sh);
      end
   endfunction

endpackage

// ==== qr_cordic_top.sv ====
// ############################
// qr_cordic_top
// 8x4 QR decomposition by folded CORDIC Givens rotations
// ############################
module qr_cordic_top
   import qr_cordic_pkg::*;
#(
   parameter int DATA_W = qr_cordic_pkg::DATA_W
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       valid,
   output logic                       in_ready,
   input  logic [NUM_COLS*DATA_W-1:0] in_data,
   output logic                       out_valid,
   output logic [NUM_COLS*DATA_W-1:0] out_data
);

   store_op_t                  op;
   row_idx_t                   row;
   col_idx_t                   col;
   step_t                      step;
   rot_code_t                  rot_code;
   logic [NUM_COLS*DATA_W-1:0] row_data;

   cordic_if vec_bus ();
   cordic_if rot_bus ();

   givens_sequencer givens_sequencer_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .op        (op),
      .row       (row),
      .col       (col),
      .step      (step)
   );

   matrix_store #(
      .DATA_W (DATA_W)
   ) matrix_store_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .op       (op),
      .row      (row),
      .col      (col),
      .in_data  (in_data),
      .out_data (row_data),
      .vec_bus  (vec_bus.store),
      .rot_bus  (rot_bus.store)
   );

   cordic_vector cordic_vector_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .step     (step),
      .op       (op),
      .bus      (vec_bus.unit),
      .rot_code (rot_code)
   );

   cordic_rotate cordic_rotate_i (
      .step     (step),
      .rot_code (rot_code),
      .bus      (rot_bus.unit)
   );

   // output bus idles at zero between bursts
   assign out_data = out_valid ? row_data : '0;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the QR CORDIC testbench with Verilator, judged from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_qr_cordic -f qr_cordic.f \
   && ./obj_dir/Vtb_qr_cordic > "$LOG" 2>&1 \
   || echo "build or simulation error"

cat "$LOG" 2>/dev/null
grep -qx "Testbench passed" "$LOG" 2>/dev/null \
   && echo "simulation result: pass" \
   || { echo "simulation result: fail"; exit 1; }

// ==== tb_qr_cordic.sv ====
// ##############################
// tb_qr_cordic
// drives the QR CORDIC top with fixed and random matrices
// ##############################
module tb_qr_cordic
   import qr_cordic_pkg::*;
();

   localparam int RESET_CYC    = 8;
   localparam int NUM_MATRICES = 6;
   localparam int MATRIX_CYC   = 400;
   localparam int WATCHDOG_CYC = NUM_MATRICES * MATRIX_CYC + RESET_CYC;
   // tolerances in LSB of Q2.10
   localparam int ELIM_TOL = 24;
   localparam int DIAG_TOL = 8;
   localparam int NORM_PCT = 6;
   localparam int NORM_ABS = 64;
   localparam int TRIV_TOL = 4;
   localparam int RAND_MAX = 256;

   logic                       clk;
   logic                       rst_n;
   logic                       valid;
   logic                       in_ready;
   logic [NUM_COLS*DATA_W-1:0] in_data;
   logic                       out_valid;
   logic [NUM_COLS*DATA_W-1:0] out_data;

   int seed;
   int err_cnt;
   int err_mark;
   int tests_run;
   int tests_failed;
   int exp_bursts;
   int run_len;
   int bursts;
   int load_cnt;
   int in_mat     [NUM_ROWS][NUM_COLS];
   int got        [NUM_ROWS][NUM_COLS];
   int replay_in  [NUM_ROWS][NUM_COLS];
   int replay_out [NUM_ROWS][NUM_COLS];

   qr_cordic_top #(
      .DATA_W (DATA_W)
   ) qr_cordic_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_data  (out_data)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic report_error(input string msg);
      $display("ERR %0t: %s", $time, msg);
      err_cnt++;
   endtask

   function automatic int abs_val(input int v);
      return (v < 0) ? -v : v;
   endfunction

   function automatic logic [NUM_COLS*DATA_W-1:0] pack_row(input int r);
      logic [NUM_COLS*DATA_W-1:0] word;
      word = '0;
      for (int c = 0; c < NUM_COLS; c++) begin
         word[c*DATA_W +: DATA_W] = DATA_W'(in_mat[r][c]);
      end
      return word;
   endfunction

   function automatic logic [NUM_COLS*DATA_W-1:0] junk_row();
      logic [NUM_COLS*DATA_W-1:0] word;
      word = '0;
      for (int c = 0; c < NUM_COLS; c++) begin
         word[c*DATA_W +: DATA_W] = DATA_W'($random(seed));
      end
      return word;
   endfunction

   task automatic clear_matrix();
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            in_mat[r][c] = 0;
         end
      end
   endtask

   task automatic random_matrix();
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            in_mat[r][c] = $random(seed) % (RAND_MAX + 1);
         end
      end
   endtask

   // rows 0..7 in order, with optional idle gaps
   task automatic send_rows(input bit gaps);
      int r;
      r = 0;
      while (r < NUM_ROWS) begin
         if (gaps && (($random(seed) & 3) == 0)) begin
            valid <= 1'b0;
         end else begin
            valid   <= 1'b1;
            in_data <= pack_row(r);
         end
         @(posedge clk);
         if (valid && in_ready) begin
            r++;
         end
      end
      valid   <= 1'b0;
      in_data <= '0;
   endtask

   task automatic collect_rows(input bit noisy);
      int beat;
      beat = 0;
      while (beat < NUM_ROWS) begin
         // stray beats only while the DUT is computing
         if (noisy && beat == 0) begin
            valid   <= 1'b1;
            in_data <= junk_row();
         end else begin
            valid <= 1'b0;
         end
         @(posedge clk);
         if (out_valid) begin
            for (int c = 0; c < NUM_COLS; c++) begin
               got[beat][c] = int'($signed(out_data[c*DATA_W +: DATA_W]));
            end
            beat++;
         end
      end
      valid   <= 1'b0;
      in_data <= '0;
   endtask

   task automatic run_matrix(input bit gaps, input bit noisy);
      send_rows(gaps);
      collect_rows(noisy);
      exp_bursts++;
      repeat (2) @(posedge clk);
      assert (bursts == exp_bursts)
         else report_error($sformatf("%0d output bursts, expected %0d", bursts, exp_bursts));
      assert (in_ready)
         else report_error("in_ready low after the output burst");
   endtask

   task automatic check_close(input int tol);
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            assert (abs_val(got[r][c] - in_mat[r][c]) <= tol)
               else report_error($sformatf("row %0d col %0d is %0d, expected %0d",
                  r, c, got[r][c], in_mat[r][c]));
         end
      end
   endtask

   // R must be upper triangular with a non-negative diagonal
   task automatic check_triangular();
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            if (r > c) begin
               assert (abs_val(got[r][c]) <= ELIM_TOL)
                  else report_error($sformatf("row %0d col %0d is %0d, expected near 0",
                     r, c, got[r][c]));
            end
         end
      end
      for (int d = 0; d < NUM_COLS; d++) begin
         assert (got[d][d] >= -DIAG_TOL)
            else report_error($sformatf("diagonal %0d is %0d, expected >= 0", d, got[d][d]));
      end
   endtask

   // rotations keep each column's sum of squares
   task automatic check_norms();
      int in_sum;
      int out_sum;
      for (int j = 0; j < NUM_COLS; j++) begin
         in_sum  = 0;
         out_sum = 0;
         for (int r = 0; r < NUM_ROWS; r++) begin
            in_sum  += in_mat[r][j] * in_mat[r][j];
            out_sum += got[r][j] * got[r][j];
         end
         assert (abs_val(out_sum - in_sum) * 100 <= in_sum * NORM_PCT + NORM_ABS * 100)
            else report_error($sformatf("column %0d sum of squares %0d, expected %0d",
               j, out_sum, in_sum));
      end
   endtask

   task automatic check_replay();
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int c = 0; c < NUM_COLS; c++) begin
            assert (got[r][c] == replay_out[r][c])
               else report_error($sformatf("row %0d col %0d is %0d, first run gave %0d",
                  r, c, got[r][c], replay_out[r][c]));
         end
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, err_cnt - err_mark);
      end
      err_mark = err_cnt;
   endtask

   // burst length and accepted rows per matrix
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_len  <= 0;
         bursts   <= 0;
         load_cnt <= 0;
      end else begin
         if (valid && in_ready) begin
            load_cnt <= load_cnt + 1;
         end
         if (out_valid) begin
            run_len <= run_len + 1;
         end else if (run_len != 0) begin
            assert (run_len == NUM_ROWS)
               else report_error($sformatf("out_valid high for %0d cycles", run_len));
            run_len  <= 0;
            bursts   <= bursts + 1;
            load_cnt <= 0;
         end
      end
   end

   a_reset_state: assert property (@(posedge clk) !rst_n |-> (in_ready && !out_valid))
      else report_error("in_ready or out_valid wrong during reset");

   a_idle_zero: assert property (@(posedge clk) !out_valid |-> (out_data == '0))
      else report_error("out_data not zero while out_valid is low");

   a_busy: assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> !in_ready)
      else report_error("in_ready high during output");

   a_load_eight: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(in_ready) |-> (load_cnt == NUM_ROWS))
      else report_error($sformatf("in_ready dropped after %0d rows", load_cnt));

   a_ready_after_out: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(in_ready) |-> $past(out_valid))
      else report_error("in_ready rose before the output ended");

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("watchdog expired, the DUT did not finish within %0d cycles", WATCHDOG_CYC);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      seed         = 32'h5791_d6f5;
      err_cnt      = 0;
      err_mark     = 0;
      tests_run    = 0;
      tests_failed = 0;
      exp_bursts   = 0;
      rst_n        = 1'b0;
      valid        = 1'b0;
      in_data      = '0;
      repeat (RESET_CYC) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (in_ready && !out_valid && out_data == '0)
         else report_error("outputs not idle after reset");
      end_test("reset");

      clear_matrix();
      run_matrix(1'b0, 1'b0);
      check_close(0);
      end_test("zero matrix");

      // already triangular, so it comes back as it went in
      clear_matrix();
      in_mat[0][0] = 256;
      in_mat[0][2] = 64;
      run_matrix(1'b0, 1'b0);
      check_close(TRIV_TOL);
      end_test("row 0 only");

      for (int k = 0; k < 3; k++) begin
         random_matrix();
         run_matrix(k == 1, 1'b0);
         check_triangular();
         check_norms();
         if (k == 0) begin
            replay_in  = in_mat;
            replay_out = got;
         end
         end_test($sformatf("random %0d", k));
      end

      // same matrix, with valid held high while the DUT computes
      in_mat = replay_in;
      run_matrix(1'b1, 1'b1);
      check_triangular();
      check_norms();
      check_replay();
      end_test("replay with stray valid");

      $display("tests %0d, ok %0d, with errors %0d, total errors %0d",
         tests_run, tests_run - tests_failed, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
